// ==== hw/i2c_master.sv ====
`timescale 1ns/100ps

module i2c_master (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [6:0] addr,
	output logic ready,
	output logic [15:0] read_data,
	output logic got_ack,
	inout wire sda,
	inout wire scl
);

	i2c_pkg::bit_phase_t state;
	logic [i2c_pkg::quarter_width-1:0] qcnt;  // Clocks within a quarter
	logic [1:0] phase;     // Quarter within the SCL period
	logic [2:0] bit_cnt;   // Bit within the byte, stop period count
	logic [1:0] byte_idx;  // 0 address, 1 and 2 data
	logic [7:0] tx_byte;   // Address with read bit
	logic [1:0] sda_sync;
	logic tick;
	logic sample;
	logic period_end;
	logic sda_low_d;
	logic scl_low_d;
	logic sda_low_q;
	logic scl_low_q;

	assign ready = (state == i2c_pkg::ph_idle);
	assign tick = (qcnt == i2c_pkg::quarter_last);
	assign sample = tick && (phase == 2'd2);      // Late in the first high quarter
	assign period_end = tick && (phase == 2'd3);

	// Open drain, released pins are pulled high on the board
	assign scl = scl_low_q ? 1'b0 : 1'bz;
	assign sda = sda_low_q ? 1'b0 : 1'bz;

	// Pin levels per state and quarter, scl is low in quarters 0 and 1
	always_comb
	begin
		scl_low_d = 1'b0;
		sda_low_d = 1'b0;
		case (state)
			i2c_pkg::ph_start:
				sda_low_d = phase[1];  // Falls while scl is high
			i2c_pkg::ph_bit, i2c_pkg::ph_ack, i2c_pkg::ph_mack:
			begin
				scl_low_d = ~phase[1];
				if (phase == 2'd0)
					sda_low_d = sda_low_q;  // Hold across the falling edge
				else if (state == i2c_pkg::ph_bit && byte_idx == 2'd0)
					sda_low_d = ~tx_byte[3'd7 - bit_cnt];  // MSB first
				else if (state == i2c_pkg::ph_mack)
					sda_low_d = (byte_idx == 2'd1);  // Ack first byte, nack second
			end
			i2c_pkg::ph_stop:
			begin
				// Rises in quarter 3 with scl high
				scl_low_d = (bit_cnt == 3'd0) && ~phase[1];
				sda_low_d = (bit_cnt == 3'd0) && (phase == 2'd1 || phase == 2'd2);
			end
			default:
			begin
				scl_low_d = 1'b0;
				sda_low_d = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= i2c_pkg::ph_idle;
			qcnt <= '0;
			phase <= 2'd0;
			bit_cnt <= 3'd0;
			byte_idx <= 2'd0;
			got_ack <= 1'b0;
			sda_low_q <= 1'b0;
			scl_low_q <= 1'b0;
			sda_sync <= 2'b11;
		end
		else
		begin
			sda_low_q <= sda_low_d;
			scl_low_q <= scl_low_d;
			sda_sync <= {sda_sync[0], sda};
			if (state == i2c_pkg::ph_idle)
			begin
				if (start)
				begin
					state <= i2c_pkg::ph_start;
					bit_cnt <= 3'd0;
					byte_idx <= 2'd0;
				end
			end
			else
			begin
				qcnt <= tick ? '0 : qcnt + 1'b1;
				if (tick)
					phase <= phase + 2'd1;  // Wraps at the period end
				if (sample && state == i2c_pkg::ph_ack)
					got_ack <= ~sda_sync[1];  // Low means acknowledged
				if (period_end)
				begin
					case (state)
						i2c_pkg::ph_start:
							state <= i2c_pkg::ph_bit;
						i2c_pkg::ph_bit:
						begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= (byte_idx == 2'd0) ? i2c_pkg::ph_ack
									: i2c_pkg::ph_mack;
						end
						i2c_pkg::ph_ack:
						begin
							state <= i2c_pkg::ph_bit;  // Data is clocked even on nack
							byte_idx <= 2'd1;
						end
						i2c_pkg::ph_mack:
						begin
							if (byte_idx == 2'd1)
							begin
								state <= i2c_pkg::ph_bit;
								byte_idx <= 2'd2;
							end
							else
								state <= i2c_pkg::ph_stop;  // bit_cnt back at 0
						end
						i2c_pkg::ph_stop:
						begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd1)
								state <= i2c_pkg::ph_idle;  // After the bus free period
						end
						default:
							state <= i2c_pkg::ph_idle;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == i2c_pkg::ph_idle && start)
			tx_byte <= {addr, 1'b1};  // Read only
		if (sample && state == i2c_pkg::ph_bit && byte_idx != 2'd0)
			read_data <= {read_data[14:0], sda_sync[1]};
	end

endmodule

// ==== hw/i2c_pkg.sv ====
package i2c_pkg;

	localparam int quarter_cycles = 4;  // System clocks per quarter SCL period
	localparam int quarter_width = (quarter_cycles > 1) ? $clog2(quarter_cycles) : 1;
	localparam logic [quarter_width-1:0] quarter_last = quarter_width'(quarter_cycles - 1);

	// One SCL period is spent per state step
	typedef enum logic [2:0] {
		ph_idle,   // Bus released, ready
		ph_start,  // Start condition
		ph_bit,    // Address or data bit
		ph_ack,    // Slave acknowledge of the address
		ph_mack,   // Master ack after byte 1, nack after byte 2
		ph_stop    // Stop condition then bus free time
	} bit_phase_t;

endpackage

// ==== hw/sensor_hub_top.sv ====
`timescale 1ns/100ps

module sensor_hub_top (
	input logic clk,
	input logic rst,
	inout wire sda,
	inout wire scl,
	output logic signed [7:0] solar_celsius,
	output logic signed [7:0] greenhouse_celsius,
	output logic signed [7:0] ambient_celsius,
	output logic signed [7:0] geothermal_celsius,
	output logic [15:0] n_lux,
	output logic [15:0] e_lux,
	output logic [15:0] s_lux,
	output logic [15:0] w_lux,
	output logic scan_done
);

	logic start;
	logic [6:0] addr;
	logic ready;
	logic [15:0] read_data;
	logic got_ack;

	sensor_poller poller (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.read_data(read_data),
		.got_ack(got_ack),
		.start(start),
		.addr(addr),
		.solar_celsius(solar_celsius),
		.greenhouse_celsius(greenhouse_celsius),
		.ambient_celsius(ambient_celsius),
		.geothermal_celsius(geothermal_celsius),
		.n_lux(n_lux),
		.e_lux(e_lux),
		.s_lux(s_lux),
		.w_lux(w_lux),
		.scan_done(scan_done)
	);

	i2c_master master (
		.clk(clk),
		.rst(rst),
		.start(start),
		.addr(addr),
		.ready(ready),
		.read_data(read_data),
		.got_ack(got_ack),
		.sda(sda),
		.scl(scl)
	);

endmodule

// ==== hw/sensor_pkg.sv ====
package sensor_pkg;

	localparam int num_sensors = 8;  // Polled once per round
	localparam int num_temp = 4;     // Index of the first light sensor
	localparam int lux_divisor = 100;

	// Polling order, temperature sensors first
	localparam logic [0:num_sensors-1][6:0] sensor_addr = {
		7'b1001000,  // Solar
		7'b1001001,  // Greenhouse
		7'b1001010,  // Ambient
		7'b1001011,  // Geothermal
		7'b1000100,  // North
		7'b1000101,  // East
		7'b1000110,  // South
		7'b1000111   // West
	};

	// One reply word, read either as a temperature or as a light level
	typedef union packed {
		struct packed {
			logic signed [8:0] half_deg;  // Two's complement, half-degree steps
			logic [6:0] pad;              // Unused low bits
		} temp;
		struct packed {
			logic [3:0] exponent;
			logic [11:0] mantissa;
		} light;
	} sensor_word_t;

endpackage

// ==== hw/sensor_poller.sv ====
`timescale 1ns/100ps

module sensor_poller (
	input logic clk,
	input logic rst,
	input logic ready,
	input logic [15:0] read_data,
	input logic got_ack,
	output logic start,
	output logic [6:0] addr,
	output logic signed [7:0] solar_celsius,
	output logic signed [7:0] greenhouse_celsius,
	output logic signed [7:0] ambient_celsius,
	output logic signed [7:0] geothermal_celsius,
	output logic [15:0] n_lux,
	output logic [15:0] e_lux,
	output logic [15:0] s_lux,
	output logic [15:0] w_lux,
	output logic scan_done
);

	sensor_pkg::sensor_word_t word;
	logic [2:0] idx;      // Sensor being read
	logic waiting;        // Transaction in flight
	logic done;
	logic last;
	logic [15:0] lsb_size;
	logic [15:0] lux_value;
	logic signed [8:0] temp_q [sensor_pkg::num_temp];
	logic [15:0] lux_q [sensor_pkg::num_sensors - sensor_pkg::num_temp];

	assign word = read_data;
	assign addr = sensor_pkg::sensor_addr[idx];
	assign start = ~waiting && ready;
	assign done = waiting && ready;  // Ready back, result valid this cycle
	assign last = (idx == 3'(sensor_pkg::num_sensors - 1));

	// Lux per mantissa step, zero when 2^exp is below the divisor
	assign lsb_size = (16'd1 << word.light.exponent) / 16'(sensor_pkg::lux_divisor);
	assign lux_value = lsb_size * {4'd0, word.light.mantissa};  // Truncated to 16 bits

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			waiting <= 1'b0;
			idx <= 3'd0;
			scan_done <= 1'b0;
			for (int i = 0; i < sensor_pkg::num_temp; i++)
				temp_q[i] <= '0;
			for (int i = 0; i < sensor_pkg::num_sensors - sensor_pkg::num_temp; i++)
				lux_q[i] <= '0;
		end
		else
		begin
			scan_done <= done && last;  // Lands with the sensor 7 update
			if (start)
				waiting <= 1'b1;
			else if (done)
			begin
				waiting <= 1'b0;
				idx <= last ? 3'd0 : idx + 3'd1;
				if (got_ack)
				begin
					// Four of each kind, so the low index bits pick the slot
					if (idx < 3'(sensor_pkg::num_temp))
						temp_q[idx[1:0]] <= word.temp.half_deg;
					else
						lux_q[idx[1:0]] <= lux_value;
				end
			end
		end
	end

	// Whole degrees, half-degree bit dropped
	assign solar_celsius = temp_q[0][8:1];
	assign greenhouse_celsius = temp_q[1][8:1];
	assign ambient_celsius = temp_q[2][8:1];
	assign geothermal_celsius = temp_q[3][8:1];

	assign n_lux = lux_q[0];
	assign e_lux = lux_q[1];
	assign s_lux = lux_q[2];
	assign w_lux = lux_q[3];

endmodule

// ==== sim.f ====
hw/sensor_pkg.sv
hw/i2c_pkg.sv
hw/i2c_master.sv
hw/sensor_poller.sv
hw/sensor_hub_top.sv
verification/sensor_slave_model.sv
verification/tb_sensor_hub.sv

// ==== verification/sensor_slave_model.sv ====
`timescale 1ns/100ps

module sensor_slave_model (
	inout wire sda,
	inout wire scl,
	input logic [15:0] reply_word,
	input logic [6:0] nack_addr,      // Outside the sensor range when all answer
	output logic [6:0] last_addr,
	output logic [15:0] last_word,    // Word served in the last read
	output logic last_acked,
	output int xfer_count
);

	logic sda_low = 1'b0;
	logic active = 1'b0;   // Between start and stop
	logic acked = 1'b0;
	logic [7:0] shift;     // Address with read bit
	logic [15:0] word;
	int edge_n;            // SCL rising edges since the start condition

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial
		xfer_count = 0;

	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active = 1'b1;  // Start condition
			edge_n = 0;
		end
	end

	always @(posedge scl)
	begin
		if (active)
		begin
			edge_n = edge_n + 1;
			if (edge_n <= 8)
				shift = {shift[6:0], sda !== 1'b0};
			if (edge_n == 8)
			begin
				// Eight sensors sit at 0x44 to 0x4b
				acked = shift[0] && shift[7:1] >= 7'h44 && shift[7:1] <= 7'h4b
					&& shift[7:1] != nack_addr;
				word = reply_word;
			end
		end
	end

	// Slave bits change only while scl is low
	always @(negedge scl)
	begin
		if (!active || !acked)
			sda_low = 1'b0;
		else if (edge_n == 8)
			sda_low = 1'b1;  // Address ack
		else if (edge_n >= 9 && edge_n <= 16)
			sda_low = !word[24 - edge_n];  // High byte, MSB first
		else if (edge_n >= 18 && edge_n <= 25)
			sda_low = !word[25 - edge_n];  // Low byte after the master ack
		else
			sda_low = 1'b0;
	end

	always @(posedge sda)
	begin
		if (active && scl === 1'b1)
		begin
			active = 1'b0;  // Stop condition
			last_addr = shift[7:1];
			last_word = word;
			last_acked = acked;
			xfer_count = xfer_count + 1;  // Updated last, the testbench waits on it
		end
	end

endmodule

// ==== verification/tb_sensor_hub.sv ====
`timescale 1ns/100ps

module tb_sensor_hub;

	localparam int rounds = 6;
	localparam int xfer_clocks = 4 * i2c_pkg::quarter_cycles * 30;  // Start to ready
	localparam int slot_clocks = xfer_clocks + 2;  // Plus the latch cycle and the start cycle
	localparam int cycle_limit = rounds * 8 * xfer_clocks * 5 / 4 + 1200;

	logic clk;
	logic rst;
	tri1 sda;
	tri1 scl;
	wire signed [7:0] celsius [4];  // Solar, greenhouse, ambient, geothermal
	wire [15:0] lux [4];            // North, east, south, west
	wire scan_done;

	logic [15:0] reply_word;
	logic [6:0] nack_addr;
	logic [6:0] seen_addr;
	logic [15:0] seen_word;
	logic seen_acked;
	int xfer_count;

	logic [31:0] lfsr = 32'hc0b0a199;
	logic [6:0] order [8] = '{7'h48, 7'h49, 7'h4a, 7'h4b, 7'h44, 7'h45, 7'h46, 7'h47};
	logic signed [7:0] exp_celsius [4] = '{8'sd0, 8'sd0, 8'sd0, 8'sd0};
	logic [15:0] exp_lux [4] = '{16'd0, 16'd0, 16'd0, 16'd0};
	int cycles = 0;
	int scan_pulses = 0;
	int last_scan = 0;  // Cycle of the previous scan_done

	sensor_hub_top uut (
		.clk(clk),
		.rst(rst),
		.sda(sda),
		.scl(scl),
		.solar_celsius(celsius[0]),
		.greenhouse_celsius(celsius[1]),
		.ambient_celsius(celsius[2]),
		.geothermal_celsius(celsius[3]),
		.n_lux(lux[0]),
		.e_lux(lux[1]),
		.s_lux(lux[2]),
		.w_lux(lux[3]),
		.scan_done(scan_done)
	);

	sensor_slave_model slave (
		.sda(sda),
		.scl(scl),
		.reply_word(reply_word),
		.nack_addr(nack_addr),
		.last_addr(seen_addr),
		.last_word(seen_word),
		.last_acked(seen_acked),
		.xfer_count(xfer_count)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);  // One step per bit
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// 2^exp / 100 truncated, times the mantissa, low 16 bits kept
	function automatic logic [15:0] lux_of(input logic [15:0] w);
		int unsigned step;
		step = (32'd1 << w[15:12]) / 100;  // Zero below an exponent of 7
		return 16'(step * w[11:0]);
	endfunction

	// One round in four has every sensor answering
	task automatic pick_nack();
		logic [15:0] v;
		take_bits(4, v);
		nack_addr = (v < 16'd12) ? order[v[2:0]] : 7'h00;
	endtask

	task automatic value_error(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_outputs();
		for (int i = 0; i < 4; i++)
		begin
			assert (celsius[i] === exp_celsius[i])
			else
				value_error($sformatf("temperature channel %0d is %0d, expected %0d",
					i, celsius[i], exp_celsius[i]));
			assert (lux[i] === exp_lux[i])
			else
				value_error($sformatf("light channel %0d is %0d, expected %0d",
					i, lux[i], exp_lux[i]));
		end
	endtask

	task automatic check_idle();
		assert (sda === 1'b1 && scl === 1'b1)
		else
			abort_run("The bus pins are driven during or right after reset");
		assert (scan_done === 1'b0)
		else
			value_error("scan_done is high during or right after reset");
		check_outputs();
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (!rst && scan_done)
			scan_pulses <= scan_pulses + 1;
		if (cycles == cycle_limit)
			abort_run("Timeout: the polling rounds did not finish within the cycle limit");
	end

	initial
	begin
		rst = 1'b1;
		nack_addr = 7'h00;
		reply_word = '0;
		repeat (16)
		begin
			@(negedge clk);
			check_idle();
		end
		pick_nack();
		take_bits(16, reply_word);
		rst = 1'b0;
		@(negedge clk);
		check_idle();
		for (int r = 0; r < rounds; r++)
		begin
			for (int s = 0; s < 8; s++)
			begin
				@(xfer_count);
				assert (seen_addr == order[s])
				else
					abort_run($sformatf("Read %0d of round %0d went to address 0x%02h, not 0x%02h",
						s, r, seen_addr, order[s]));
				if (seen_acked && s < 4)
					exp_celsius[s] = seen_word[15:8];  // Whole degrees of the 9-bit reading
				else if (seen_acked)
					exp_lux[s - 4] = lux_of(seen_word);
				@(negedge clk);
				if (s == 7)
					pick_nack();  // Chosen before the next round starts
				take_bits(16, reply_word);
			end
			do
				@(negedge clk);
			while (scan_done !== 1'b1);
			assert (xfer_count == 8 * (r + 1) && scan_pulses == r)
			else
				abort_run($sformatf("scan_done came after %0d reads with %0d earlier pulses",
					xfer_count, scan_pulses));
			assert (r == 0 || cycles - last_scan == 8 * slot_clocks)
			else
				value_error($sformatf("scan_done spacing is %0d cycles, expected %0d",
					cycles - last_scan, 8 * slot_clocks));
			last_scan = cycles;
			check_outputs();
		end
		$display("No errors");
		$finish;
	end

endmodule
